// ==== include/xgmii_stats_params.svh ====
`ifndef XGMII_STATS_PARAMS_SVH
`define XGMII_STATS_PARAMS_SVH

// xgmii lane geometry
`define XGMII_LANES          8
`define XGMII_BYTE_WIDTH     8
`define XGMII_CHAR_WIDTH     9
`define XGMII_DATA_WIDTH     64
`define XGMII_CTRL_WIDTH     8

// per-lane statistics
`define STAT_COUNT_WIDTH     16
`define XGMII_STAT_KINDS     4

// character codes seen with the control bit set
`define XGMII_IDLE_CHAR      8'h07
`define XGMII_ERROR_CHAR     8'hFE

// csr bus
`define CSR_ADDR_WIDTH       8
`define CSR_DATA_WIDTH       32

// counters occupy 00..1F at lane*4 + kind
`define CSR_SCRATCH_ADDR     8'h40
`define CSR_CLEAR_ADDR       8'h41

`endif

// ==== design/xgmii_stats_pkg.sv ====
package xgmii_stats_pkg;

    `include "xgmii_stats_params.svh"

    typedef logic [`XGMII_DATA_WIDTH-1:0]                   xgmii_data_t;
    typedef logic [`XGMII_CTRL_WIDTH-1:0]                   xgmii_ctrl_t;

    // control bit above the data byte
    typedef logic [`XGMII_CHAR_WIDTH-1:0]                   xgmii_lane_char_t;

    // lane 7 in the top nine bits
    typedef logic [`XGMII_LANES*`XGMII_CHAR_WIDTH-1:0]      xgmii_word_t;

    typedef logic [`STAT_COUNT_WIDTH-1:0]                   stat_count_t;
    typedef logic [`CSR_ADDR_WIDTH-1:0]                     csr_addr_t;
    typedef logic [`CSR_DATA_WIDTH-1:0]                     csr_data_t;
    typedef logic [$clog2(`XGMII_LANES)-1:0]                lane_index_t;

    typedef enum logic {
        CSR_IDLE,
        CSR_RESPOND
    } csr_state_e;

endpackage

// ==== design/lane_stats_if.sv ====
`timescale 1ns/1ps

interface lane_stats_if;
    import xgmii_stats_pkg::*;

    stat_count_t data_count;
    stat_count_t idle_count;
    stat_count_t error_count;
    stat_count_t control_count;

    // counter side
    modport lane (
        output data_count,
        output idle_count,
        output error_count,
        output control_count
    );

    // readout side
    modport csr (
        input  data_count,
        input  idle_count,
        input  error_count,
        input  control_count
    );

endinterface

// ==== design/xgmii_rx_lane_split.sv ====
`timescale 1ns/1ps
`include "xgmii_stats_params.svh"

module xgmii_rx_lane_split (
    input  logic                              rx_clk_156,
    input  logic                              reset_i,
    input  logic                              xgmii_rx_valid_i,
    input  xgmii_stats_pkg::xgmii_data_t      xgmii_rx_data_i,
    input  xgmii_stats_pkg::xgmii_ctrl_t      xgmii_rx_control_i,
    output logic                              lane_valid_o,
    output xgmii_stats_pkg::xgmii_lane_char_t lane_char_o [`XGMII_LANES]
);
    import xgmii_stats_pkg::*;

    xgmii_word_t rx_word;
    xgmii_word_t rx_word_q;
    logic        rx_valid_q;

    // interleave puts {ctrl[n], data byte n} in each lane with lane 7 on top
    always_comb begin
        for (int lane = 0; lane < `XGMII_LANES; lane++) begin
            rx_word[lane*`XGMII_CHAR_WIDTH +: `XGMII_CHAR_WIDTH] = {
                xgmii_rx_control_i[lane],
                xgmii_rx_data_i[lane*`XGMII_BYTE_WIDTH +: `XGMII_BYTE_WIDTH]
            };
        end
    end

    always_ff @(posedge rx_clk_156) begin
        if (reset_i) begin
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= xgmii_rx_valid_i;
        end
    end

    // word only loads alongside valid
    always_ff @(posedge rx_clk_156) begin
        if (xgmii_rx_valid_i) begin
            rx_word_q <= rx_word;
        end
    end

    assign lane_valid_o = rx_valid_q;

    for (genvar g = 0; g < `XGMII_LANES; g++) begin : gen_lane_out
        assign lane_char_o[g] = rx_word_q[g*`XGMII_CHAR_WIDTH +: `XGMII_CHAR_WIDTH];
    end

    // serdes must drive a defined strobe once out of reset
    assert property (@(posedge rx_clk_156) disable iff (reset_i)
        !$isunknown(xgmii_rx_valid_i))
        else $error("xgmii_rx_valid_i is unknown");

endmodule

// ==== design/xgmii_lane_counter.sv ====
`timescale 1ns/1ps
`include "xgmii_stats_params.svh"

module xgmii_lane_counter (
    input  logic                              rx_clk_156,
    input  logic                              reset_i,
    input  logic                              lane_valid_i,
    input  xgmii_stats_pkg::xgmii_lane_char_t lane_char_i,
    input  logic                              clear_i,
    lane_stats_if.lane                        stats_o
);
    import xgmii_stats_pkg::*;

    logic                           is_ctrl;
    logic [`XGMII_BYTE_WIDTH-1:0]   char_byte;
    logic [`XGMII_STAT_KINDS-1:0]   hit;
    stat_count_t                    count_q [`XGMII_STAT_KINDS];

    assign is_ctrl   = lane_char_i[`XGMII_BYTE_WIDTH];
    assign char_byte = lane_char_i[`XGMII_BYTE_WIDTH-1:0];

    // order matches the csr map: data, idle, error, control
    always_comb begin
        hit = '0;
        if (!is_ctrl) begin
            hit[0] = 1'b1;
        end else if (char_byte == `XGMII_IDLE_CHAR) begin
            hit[1] = 1'b1;
        end else if (char_byte == `XGMII_ERROR_CHAR) begin
            hit[2] = 1'b1;
        end else begin
            hit[3] = 1'b1;
        end
    end

    // clear beats a same-cycle increment
    always_ff @(posedge rx_clk_156) begin
        if (reset_i || clear_i) begin
            for (int k = 0; k < `XGMII_STAT_KINDS; k++) begin
                count_q[k] <= '0;
            end
        end else if (lane_valid_i) begin
            for (int k = 0; k < `XGMII_STAT_KINDS; k++) begin
                // saturate at all ones
                if (hit[k] && count_q[k] != '1) begin
                    count_q[k] <= count_q[k] + 1'b1;
                end
            end
        end
    end

    assign stats_o.data_count    = count_q[0];
    assign stats_o.idle_count    = count_q[1];
    assign stats_o.error_count   = count_q[2];
    assign stats_o.control_count = count_q[3];

    for (genvar k = 0; k < `XGMII_STAT_KINDS; k++) begin : gen_sat_check
        // a full counter only returns to zero through clear
        assert property (@(posedge rx_clk_156) disable iff (reset_i)
            (count_q[k] == '1) && !clear_i |=> count_q[k] != '0)
            else $error("lane counter %0d wrapped past all ones", k);
    end

endmodule

// ==== design/xgmii_stats_csr.sv ====
`timescale 1ns/1ps
`include "xgmii_stats_params.svh"

module xgmii_stats_csr (
    input  logic                       rx_clk_156,
    input  logic                       reset_i,
    input  logic                       csr_read_i,
    input  logic                       csr_write_i,
    input  xgmii_stats_pkg::csr_addr_t csr_address_i,
    input  xgmii_stats_pkg::csr_data_t csr_writedata_i,
    output xgmii_stats_pkg::csr_data_t csr_readdata_o,
    output logic                       csr_waitrequest_o,
    output logic                       clear_o,
    lane_stats_if.csr                  stats_i [`XGMII_LANES]
);
    import xgmii_stats_pkg::*;

    csr_state_e  state_q;
    csr_state_e  state_d;
    csr_addr_t   read_addr_q;
    csr_data_t   scratch_q;
    logic        clear_q;
    lane_index_t sel_lane;
    logic [$clog2(`XGMII_STAT_KINDS)-1:0] sel_kind;
    stat_count_t lane_counts [`XGMII_LANES][`XGMII_STAT_KINDS];

    // counters gathered per lane in csr map order
    for (genvar g = 0; g < `XGMII_LANES; g++) begin : gen_gather
        assign lane_counts[g][0] = stats_i[g].data_count;
        assign lane_counts[g][1] = stats_i[g].idle_count;
        assign lane_counts[g][2] = stats_i[g].error_count;
        assign lane_counts[g][3] = stats_i[g].control_count;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            CSR_IDLE:    if (csr_read_i) state_d = CSR_RESPOND;
            CSR_RESPOND: state_d = CSR_IDLE;
            default:     state_d = CSR_IDLE;
        endcase
    end

    always_ff @(posedge rx_clk_156) begin
        if (reset_i) begin
            state_q <= CSR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge rx_clk_156) begin
        if (state_q == CSR_IDLE && csr_read_i) begin
            read_addr_q <= csr_address_i;
        end
    end

    // stall the first cycle of every read
    assign csr_waitrequest_o = (state_q == CSR_IDLE) && csr_read_i;

    assign sel_lane = read_addr_q[2 +: $bits(lane_index_t)];
    assign sel_kind = read_addr_q[$bits(sel_kind)-1:0];

    always_comb begin
        csr_readdata_o = '0;
        if (state_q == CSR_RESPOND) begin
            if (read_addr_q < csr_addr_t'(`XGMII_LANES * `XGMII_STAT_KINDS)) begin
                csr_readdata_o = csr_data_t'(lane_counts[sel_lane][sel_kind]);
            end else if (read_addr_q == `CSR_SCRATCH_ADDR) begin
                csr_readdata_o = scratch_q;
            end
        end
    end

    // writes finish in the cycle they are presented
    always_ff @(posedge rx_clk_156) begin
        if (reset_i) begin
            scratch_q <= '0;
            clear_q   <= 1'b0;
        end else begin
            clear_q <= csr_write_i && (csr_address_i == `CSR_CLEAR_ADDR);
            if (csr_write_i && csr_address_i == `CSR_SCRATCH_ADDR) begin
                scratch_q <= csr_writedata_i;
            end
        end
    end

    assign clear_o = clear_q;

    assert property (@(posedge rx_clk_156) disable iff (reset_i)
        !(csr_read_i && csr_write_i))
        else $error("csr read and write asserted together");

    // master holds read through the stall, then gets data next cycle
    assert property (@(posedge rx_clk_156) disable iff (reset_i)
        csr_read_i && csr_waitrequest_o |=> csr_read_i && !csr_waitrequest_o)
        else $error("csr read did not complete on its second cycle");

endmodule

// ==== design/xgmii_lane_stats.sv ====
`timescale 1ns/1ps
`include "xgmii_stats_params.svh"

module xgmii_lane_stats (
    input  logic                         rx_clk_156,
    input  logic                         reset_i,
    input  logic                         xgmii_rx_valid_i,
    input  xgmii_stats_pkg::xgmii_data_t xgmii_rx_data_i,
    input  xgmii_stats_pkg::xgmii_ctrl_t xgmii_rx_control_i,
    input  logic                         csr_read_i,
    input  logic                         csr_write_i,
    input  xgmii_stats_pkg::csr_addr_t   csr_address_i,
    input  xgmii_stats_pkg::csr_data_t   csr_writedata_i,
    output xgmii_stats_pkg::csr_data_t   csr_readdata_o,
    output logic                         csr_waitrequest_o
);
    import xgmii_stats_pkg::*;

    logic             lane_valid;
    xgmii_lane_char_t lane_char [`XGMII_LANES];
    logic             stats_clear;

    lane_stats_if lane_stats [`XGMII_LANES] ();

    xgmii_rx_lane_split lane_split_inst (
        .rx_clk_156         (rx_clk_156),
        .reset_i            (reset_i),
        .xgmii_rx_valid_i   (xgmii_rx_valid_i),
        .xgmii_rx_data_i    (xgmii_rx_data_i),
        .xgmii_rx_control_i (xgmii_rx_control_i),
        .lane_valid_o       (lane_valid),
        .lane_char_o        (lane_char)
    );

    // one counter block per byte lane
    for (genvar n = 0; n < `XGMII_LANES; n++) begin : gen_lane
        xgmii_lane_counter lane_counter_inst (
            .rx_clk_156   (rx_clk_156),
            .reset_i      (reset_i),
            .lane_valid_i (lane_valid),
            .lane_char_i  (lane_char[n]),
            .clear_i      (stats_clear),
            .stats_o      (lane_stats[n])
        );
    end

    xgmii_stats_csr stats_csr_inst (
        .rx_clk_156        (rx_clk_156),
        .reset_i           (reset_i),
        .csr_read_i        (csr_read_i),
        .csr_write_i       (csr_write_i),
        .csr_address_i     (csr_address_i),
        .csr_writedata_i   (csr_writedata_i),
        .csr_readdata_o    (csr_readdata_o),
        .csr_waitrequest_o (csr_waitrequest_o),
        .clear_o           (stats_clear),
        .stats_i           (lane_stats)
    );

endmodule

// ==== testbench/tb_xgmii_lane_stats.sv ====
`timescale 1ns/1ps
`include "xgmii_stats_params.svh"

module tb_xgmii_lane_stats;
    import xgmii_stats_pkg::*;

    localparam int RANDOM_WORDS = 400;
    localparam int FILL_WORDS   = 70000;
    localparam int MAX_READS    = 256;
    localparam longint WATCHDOG_NS = (RANDOM_WORDS + FILL_WORDS + MAX_READS * 4 + 1000) * 100;

    logic        rx_clk_156;
    logic        reset_i;
    logic        rx_valid;
    xgmii_data_t rx_data;
    xgmii_ctrl_t rx_control;
    logic        csr_read;
    logic        csr_write;
    csr_addr_t   csr_address;
    csr_data_t   csr_writedata;
    csr_data_t   csr_readdata;
    logic        csr_waitrequest;

    integer      seed = 32'h7dd1;
    int          value_errors = 0;
    int          handshake_errors = 0;
    stat_count_t model_count [`XGMII_LANES][4];
    csr_data_t   model_scratch;

    xgmii_lane_stats xgmii_lane_stats_i (
        .rx_clk_156         (rx_clk_156),
        .reset_i            (reset_i),
        .xgmii_rx_valid_i   (rx_valid),
        .xgmii_rx_data_i    (rx_data),
        .xgmii_rx_control_i (rx_control),
        .csr_read_i         (csr_read),
        .csr_write_i        (csr_write),
        .csr_address_i      (csr_address),
        .csr_writedata_i    (csr_writedata),
        .csr_readdata_o     (csr_readdata),
        .csr_waitrequest_o  (csr_waitrequest)
    );

    initial begin
        rx_clk_156 = 1'b0;
        forever #50 rx_clk_156 = ~rx_clk_156;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    task automatic next_drive_point();
        @(posedge rx_clk_156);
        #5;
    endtask

    task automatic pause_stimulus(input int cycles);
        rx_valid = 1'b0;
        repeat (cycles) next_drive_point();
    endtask

    // reference classification picks one of four counters per valid character
    task automatic count_char(input int lane, input logic ctrl, input logic [7:0] char_byte);
        int kind;
        if (!ctrl) begin
            kind = 0;
        end else if (char_byte == `XGMII_IDLE_CHAR) begin
            kind = 1;
        end else if (char_byte == `XGMII_ERROR_CHAR) begin
            kind = 2;
        end else begin
            kind = 3;
        end
        if (model_count[lane][kind] != 16'hFFFF) begin
            model_count[lane][kind]++;
        end
    endtask

    task automatic send_random_word(input bit idle_on_lane0, input bit always_valid);
        int         pick;
        logic [7:0] lane_byte;
        logic       lane_ctrl;
        rx_valid = always_valid ? 1'b1 : ($unsigned($random(seed)) % 4 != 0);
        for (int lane = 0; lane < `XGMII_LANES; lane++) begin
            pick      = $unsigned($random(seed)) % 10;
            lane_byte = $random(seed);
            lane_ctrl = (pick >= 5);
            // weights are half data, then idle, error, start/terminate and other control
            if (pick == 5 || pick == 6) begin
                lane_byte = 8'h07;
            end else if (pick == 7) begin
                lane_byte = 8'hFE;
            end else if (pick == 8) begin
                lane_byte = lane_byte[0] ? 8'hFB : 8'hFD;
            end
            if (idle_on_lane0 && lane == 0) begin
                lane_ctrl = 1'b1;
                lane_byte = 8'h07;
            end
            rx_control[lane]     = lane_ctrl;
            rx_data[lane*8 +: 8] = lane_byte;
            if (rx_valid) begin
                count_char(lane, lane_ctrl, lane_byte);
            end
        end
        next_drive_point();
    endtask

    task automatic csr_read_word(input csr_addr_t addr, output csr_data_t data);
        int cycles;
        bit done;
        cycles      = 0;
        done        = 1'b0;
        data        = '0;
        csr_read    = 1'b1;
        csr_address = addr;
        while (!done && cycles < 8) begin
            @(negedge rx_clk_156);
            cycles++;
            if (!csr_waitrequest) begin
                data = csr_readdata;
                done = 1'b1;
            end
            next_drive_point();
        end
        csr_read = 1'b0;
        if (!done) begin
            $display("read of address %h at %0t ns never completed, waitrequest stayed high",
                     addr, $time);
            handshake_errors++;
        end else if (cycles != 2) begin
            $display("read of address %h at %0t ns: waitrequest fell in cycle %0d, not cycle 2",
                     addr, $time, cycles);
            handshake_errors++;
        end
    endtask

    task automatic csr_write_word(input csr_addr_t addr, input csr_data_t data);
        csr_write     = 1'b1;
        csr_address   = addr;
        csr_writedata = data;
        @(negedge rx_clk_156);
        if (csr_waitrequest !== 1'b0) begin
            $display("write to address %h at %0t ns saw waitrequest high", addr, $time);
            handshake_errors++;
        end
        next_drive_point();
        csr_write = 1'b0;
        if (addr == `CSR_SCRATCH_ADDR) begin
            model_scratch = data;
        end else if (addr == `CSR_CLEAR_ADDR) begin
            for (int lane = 0; lane < `XGMII_LANES; lane++) begin
                for (int kind = 0; kind < 4; kind++) begin
                    model_count[lane][kind] = '0;
                end
            end
        end
    endtask

    task automatic check_counter(input int lane, input int kind,
                                 input stat_count_t expected, input stat_count_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: lane %0d counter %0d read %h, expected %h",
                     $time, lane, kind, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_csr_word(input csr_addr_t addr,
                                  input csr_data_t expected, input csr_data_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: address %h read %h, expected %h",
                     $time, addr, actual, expected);
            value_errors++;
        end
    endtask

    task automatic read_all_counters();
        csr_data_t word;
        for (int lane = 0; lane < `XGMII_LANES; lane++) begin
            for (int kind = 0; kind < 4; kind++) begin
                csr_read_word(csr_addr_t'(lane * 4 + kind), word);
                check_counter(lane, kind, model_count[lane][kind], stat_count_t'(word));
            end
        end
    endtask

    initial begin
        csr_data_t word;
        csr_data_t value;
        csr_addr_t addr;
        reset_i       = 1'b1;
        rx_valid      = 1'b0;
        rx_data       = '0;
        rx_control    = '0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_address   = '0;
        csr_writedata = '0;
        model_scratch = '0;
        for (int lane = 0; lane < `XGMII_LANES; lane++) begin
            for (int kind = 0; kind < 4; kind++) begin
                model_count[lane][kind] = '0;
            end
        end
        repeat (16) @(posedge rx_clk_156);
        #5;
        reset_i = 1'b0;

        // reset values and idle bus
        @(negedge rx_clk_156);
        if (csr_waitrequest !== 1'b0) begin
            $display("waitrequest is not low while the CSR bus is idle after reset");
            handshake_errors++;
        end
        next_drive_point();
        read_all_counters();
        csr_read_word(`CSR_SCRATCH_ADDR, word);
        check_csr_word(`CSR_SCRATCH_ADDR, model_scratch, word);

        repeat (RANDOM_WORDS) send_random_word(1'b0, 1'b0);
        pause_stimulus(3);
        read_all_counters();

        // clear command and unmapped space read as zero
        csr_read_word(`CSR_CLEAR_ADDR, word);
        check_csr_word(`CSR_CLEAR_ADDR, '0, word);
        repeat (16) begin
            addr = 8'h20 + csr_addr_t'($unsigned($random(seed)) % 224);
            if (addr == `CSR_SCRATCH_ADDR) begin
                addr = 8'h42;
            end
            csr_read_word(addr, word);
            check_csr_word(addr, '0, word);
        end

        repeat (8) begin
            value = $random(seed);
            csr_write_word(`CSR_SCRATCH_ADDR, value);
            csr_read_word(`CSR_SCRATCH_ADDR, word);
            check_csr_word(`CSR_SCRATCH_ADDR, model_scratch, word);
        end
        // counters are read only
        repeat (8) begin
            addr  = csr_addr_t'($unsigned($random(seed)) % 32);
            value = $random(seed);
            csr_write_word(addr, value);
        end
        pause_stimulus(3);
        read_all_counters();

        csr_write_word(`CSR_CLEAR_ADDR, '0);
        pause_stimulus(3);
        read_all_counters();
        // long idle run on lane 0 to hit saturation
        repeat (FILL_WORDS) send_random_word(1'b1, 1'b1);
        pause_stimulus(3);
        read_all_counters();
        csr_read_word(8'h01, word);
        check_counter(0, 1, 16'hFFFF, stat_count_t'(word));

        $display("value errors: %0d, handshake errors: %0d", value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
design/xgmii_stats_pkg.sv
design/lane_stats_if.sv
design/xgmii_rx_lane_split.sv
design/xgmii_lane_counter.sv
design/xgmii_stats_csr.sv
design/xgmii_lane_stats.sv
testbench/tb_xgmii_lane_stats.sv

// ==== Bender.yml ====
package:
  name: xgmii_lane_stats

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/xgmii_stats_pkg.sv
      - design/lane_stats_if.sv
      - design/xgmii_rx_lane_split.sv
      - design/xgmii_lane_counter.sv
      - design/xgmii_stats_csr.sv
      - design/xgmii_lane_stats.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_xgmii_lane_stats.sv
